//--- logic/axis_merge_pkg.sv
// shared widths, beat structs and arbiter states for the four-port stream merge
// import inside module bodies, use scoped names in port lists
package axis_merge_pkg;

    // number of merged source ports
    localparam int num_ports = 4;

    // width of a source port index, also the width of tid
    localparam int port_w = 2;

    // payload widths
    localparam int data_w = 32;
    localparam int keep_w = 4;

    // one stream beat as carried through the merge
    typedef struct packed {
        // payload word
        logic [data_w-1:0] tdata;
        // byte enables, one per tdata byte
        logic [keep_w-1:0] tkeep;
        // sideband bit, passed through untouched
        logic              tuser;
        // marks the final beat of a packet
        logic              tlast;
    } axis_beat_t;

    // beat on the merged output, tagged with its source port
    typedef struct packed {
        // unchanged source beat
        axis_beat_t        beat;
        // index of the port the beat came from
        logic [port_w-1:0] tid;
    } merged_beat_t;

    // packet arbiter states
    typedef enum logic {
        // no packet in progress, grant follows requests
        arb_idle,
        // packet in progress, grant held until tlast leaves
        arb_locked
    } arb_state_t;

endpackage

//--- logic/axis_skid_buffer.sv
// two-entry input buffer for one source port, with s_ready driven from a flop
// one instance per port sits between the outside source and the merge core
`timescale 1ns/1ns

module axis_skid_buffer (
    input  logic                     aclk,
    input  logic                     reset,
    input  logic                     s_valid,
    output logic                     s_ready,
    input  axis_merge_pkg::axis_beat_t s_beat,
    output logic                     buf_valid,
    input  logic                     buf_ready,
    output axis_merge_pkg::axis_beat_t buf_beat
);
    import axis_merge_pkg::*;

    // main entry feeds the core, skid entry catches the beat that
    // arrives in the cycle before s_ready drops
    axis_beat_t main_beat;
    axis_beat_t skid_beat;
    logic       main_valid;
    logic       skid_valid;
    logic       main_valid_d;
    logic       skid_valid_d;

    // payload load enables
    logic       load_main_in;
    logic       load_main_skid;
    logic       load_skid;

    logic       push;
    logic       pop;

    assign push = s_valid & s_ready;
    assign pop  = main_valid & buf_ready;

    always_comb begin
        main_valid_d   = main_valid;
        skid_valid_d   = skid_valid;
        load_main_in   = 1'b0;
        load_main_skid = 1'b0;
        load_skid      = 1'b0;
        if (skid_valid) begin
            // both full, s_ready is low so no push here
            if (pop) begin
                load_main_skid = 1'b1;
                skid_valid_d   = 1'b0;
            end
        end else if (main_valid) begin
            if (pop && push) begin
                // drain and refill main in the same cycle
                load_main_in = 1'b1;
            end else if (pop) begin
                main_valid_d = 1'b0;
            end else if (push) begin
                // main is stuck, park the new beat in skid
                load_skid    = 1'b1;
                skid_valid_d = 1'b1;
            end
        end else if (push) begin
            load_main_in = 1'b1;
            main_valid_d = 1'b1;
        end
    end

    // control flops
    always_ff @(posedge aclk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            s_ready    <= 1'b1;
        end else begin
            main_valid <= main_valid_d;
            skid_valid <= skid_valid_d;
            // ready only drops once both entries hold a beat
            s_ready    <= ~skid_valid_d;
        end
    end

    // payload flops
    always_ff @(posedge aclk) begin
        if (load_main_in)
            main_beat <= s_beat;
        else if (load_main_skid)
            main_beat <= skid_beat;
        if (load_skid)
            skid_beat <= s_beat;
    end

    assign buf_valid = main_valid;
    assign buf_beat  = main_beat;

endmodule

//--- logic/packet_arbiter.sv
// packet-locked round-robin arbiter over the source port buffers
// grant is held on one port from its first accepted beat until the tlast beat
`timescale 1ns/1ns

module packet_arbiter (
    input  logic                              aclk,
    input  logic                              reset,
    input  logic [axis_merge_pkg::num_ports-1:0] req,
    input  logic                              take,
    input  logic                              take_last,
    output logic                              grant_valid,
    output logic [axis_merge_pkg::port_w-1:0]    grant_port
);
    import axis_merge_pkg::*;

    arb_state_t        state;
    arb_state_t        state_d;

    // last granted port, also the locked port while a packet is open
    logic [port_w-1:0] last_port;
    logic [port_w-1:0] last_port_d;

    // round-robin search result
    logic              rr_found;
    logic [port_w-1:0] rr_port;

    // search cyclically from the port after the last one granted
    always_comb begin
        logic [port_w-1:0] idx;
        rr_found = 1'b0;
        rr_port  = last_port;
        for (int i = 1; i <= num_ports; i++) begin
            // index wraps naturally at port_w bits
            idx = last_port + port_w'(i);
            if (!rr_found && req[idx]) begin
                rr_found = 1'b1;
                rr_port  = idx;
            end
        end
    end

    // grant outputs
    always_comb begin
        if (state == arb_locked) begin
            // hold the open packet's port whatever else requests
            grant_valid = 1'b1;
            grant_port  = last_port;
        end else begin
            // idle grant follows requests in the same cycle
            grant_valid = rr_found;
            grant_port  = rr_port;
        end
    end

    // next state
    always_comb begin
        state_d     = state;
        last_port_d = last_port;
        case (state)
            arb_idle: begin
                if (take) begin
                    last_port_d = grant_port;
                    // single-beat packet needs no lock
                    if (!take_last)
                        state_d = arb_locked;
                end
            end
            arb_locked: begin
                // release, new grant searched next cycle
                if (take_last)
                    state_d = arb_idle;
            end
            default: begin
                state_d = arb_idle;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= arb_idle;
            // previous port counts as the highest so port 0 goes first
            last_port <= port_w'(num_ports - 1);
        end else begin
            state     <= state_d;
            last_port <= last_port_d;
        end
    end

endmodule

//--- logic/merge_output_stage.sv
// output register of the merge, muxes the granted port's beat and tags it with tid
// also reports accepted beats back to the arbiter as take and take_last
`timescale 1ns/1ns

module merge_output_stage (
    input  logic                                    aclk,
    input  logic                                    reset,
    input  logic                                    grant_valid,
    input  logic [axis_merge_pkg::port_w-1:0]          grant_port,
    input  logic [axis_merge_pkg::num_ports-1:0]       buf_valid,
    input  axis_merge_pkg::axis_beat_t [axis_merge_pkg::num_ports-1:0] buf_beat,
    output logic [axis_merge_pkg::num_ports-1:0]       buf_ready,
    output logic                                    take,
    output logic                                    take_last,
    output logic                                    m_valid,
    input  logic                                    m_ready,
    output axis_merge_pkg::merged_beat_t               m_beat
);
    import axis_merge_pkg::*;

    // register can load this cycle
    logic       accept_en;

    // beat of the granted port
    axis_beat_t sel_beat;
    logic       sel_valid;

    // register empty or being drained downstream
    assign accept_en = ~m_valid | m_ready;

    assign sel_beat  = buf_beat[grant_port];
    assign sel_valid = buf_valid[grant_port];

    // ready goes only to the granted port, and only when the register can load
    always_comb begin
        buf_ready = '0;
        for (int i = 0; i < num_ports; i++) begin
            if (grant_valid && (grant_port == port_w'(i)))
                buf_ready[i] = accept_en;
        end
    end

    // handshake seen by the arbiter, computed once here
    assign take      = grant_valid & sel_valid & accept_en;
    assign take_last = take & sel_beat.tlast;

    // output valid
    always_ff @(posedge aclk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (accept_en) begin
            // empty the register when nothing new arrives
            m_valid <= take;
        end
    end

    // output payload, held while m_ready is low
    always_ff @(posedge aclk) begin
        if (take) begin
            m_beat.beat <= sel_beat;
            m_beat.tid  <= grant_port;
        end
    end

endmodule

//--- logic/axis_merge_top.sv
// four-port packet-preserving stream merge
// source beats pass skid buffers, a locked arbiter and one output register
`timescale 1ns/1ns

module axis_merge_top (
    input  logic                                    aclk,
    input  logic                                    reset,
    input  logic [axis_merge_pkg::num_ports-1:0]       s_valid,
    output logic [axis_merge_pkg::num_ports-1:0]       s_ready,
    input  axis_merge_pkg::axis_beat_t [axis_merge_pkg::num_ports-1:0] s_beat,
    output logic                                    m_valid,
    input  logic                                    m_ready,
    output axis_merge_pkg::merged_beat_t               m_beat
);
    import axis_merge_pkg::*;

    // buffered per-port streams
    logic       [num_ports-1:0] buf_valid;
    logic       [num_ports-1:0] buf_ready;
    axis_beat_t [num_ports-1:0] buf_beat;

    // arbiter to output stage
    logic                       grant_valid;
    logic       [port_w-1:0]    grant_port;

    // accepted beat report back to the arbiter
    logic                       take;
    logic                       take_last;

    // one skid buffer per source port
    for (genvar i = 0; i < num_ports; i++) begin : skid_gen
        axis_skid_buffer skid_i (
            .aclk      (aclk),
            .reset     (reset),
            .s_valid   (s_valid[i]),
            .s_ready   (s_ready[i]),
            .s_beat    (s_beat[i]),
            .buf_valid (buf_valid[i]),
            .buf_ready (buf_ready[i]),
            .buf_beat  (buf_beat[i])
        );
    end

    // requests are the buffered valids
    packet_arbiter arb_i (
        .aclk        (aclk),
        .reset       (reset),
        .req         (buf_valid),
        .take        (take),
        .take_last   (take_last),
        .grant_valid (grant_valid),
        .grant_port  (grant_port)
    );

    merge_output_stage out_i (
        .aclk        (aclk),
        .reset       (reset),
        .grant_valid (grant_valid),
        .grant_port  (grant_port),
        .buf_valid   (buf_valid),
        .buf_beat    (buf_beat),
        .buf_ready   (buf_ready),
        .take        (take),
        .take_last   (take_last),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_beat      (m_beat)
    );

endmodule

//--- dv/axis_merge_props.sv
// concurrent checks on the merge handshake and arbiter lock
// bound into axis_merge_top at the end of this file
`timescale 1ns/1ns

module axis_merge_props (
    input  logic                                  aclk,
    input  logic                                  reset,
    input  logic                                  m_valid,
    input  logic                                  m_ready,
    input  axis_merge_pkg::merged_beat_t          m_beat,
    input  logic [axis_merge_pkg::num_ports-1:0]  buf_ready,
    input  axis_merge_pkg::arb_state_t            arb_state,
    input  logic [axis_merge_pkg::port_w-1:0]     grant_port,
    input  logic                                  take_last
);
    import axis_merge_pkg::*;

    // failed assertions so far, read by the testbench
    int assert_errors = 0;

    // a stalled output beat stays put until taken
    property stall_holds_beat;
        @(posedge aclk) disable iff (reset)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat));
    endproperty

    // open packet keeps its port until the tlast beat leaves
    property lock_holds_port;
        @(posedge aclk) disable iff (reset)
        (arb_state == arb_locked && !take_last) |=> $stable(grant_port);
    endproperty

    // only the granted buffer may see ready
    property single_ready;
        @(posedge aclk) disable iff (reset)
        $onehot0(buf_ready);
    endproperty

    stall_holds_beat_a: assert property (stall_holds_beat)
        else begin
            $error("output beat changed while m_ready was low");
            assert_errors++;
        end
    lock_holds_port_a: assert property (lock_holds_port)
        else begin
            $error("grant moved off a locked port before tlast");
            assert_errors++;
        end
    single_ready_a: assert property (single_ready)
        else begin
            $error("more than one buffer ready at once");
            assert_errors++;
        end

endmodule

bind axis_merge_top axis_merge_props props_i (
    .aclk       (aclk),
    .reset      (reset),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .m_beat     (m_beat),
    .buf_ready  (buf_ready),
    .arb_state  (arb_i.state),
    .grant_port (grant_port),
    .take_last  (take_last)
);

//--- dv/axis_merge_tb.sv
// testbench for the four-port stream merge, reads packet vectors and checks merged beats
// each test starts from reset and prints one result line when it finishes
`timescale 1ns/1ns

module axis_merge_tb;
    import axis_merge_pkg::*;

    logic                       aclk;
    logic                       reset;
    logic       [num_ports-1:0] s_valid;
    logic       [num_ports-1:0] s_ready;
    axis_beat_t [num_ports-1:0] s_beat;
    logic                       m_valid;
    logic                       m_ready;
    merged_beat_t               m_beat;

    // tests and beats as read from the vector file
    string      test_name[$];
    int         test_mode[$];
    string      test_seq[$];
    int         beat_test[$];
    int         beat_port[$];
    axis_beat_t beat_val[$];

    // stimulus and expected beats of the running test, one queue per port
    axis_beat_t src_q[num_ports][$];
    axis_beat_t exp_q[num_ports][$];

    string       cur_test;
    int          errors;
    int          pass_count;
    int          fail_count;
    int          total_beats;
    logic        test_done;
    logic [31:0] lcg_state;

    axis_merge_top dut_i (
        .aclk    (aclk),
        .reset   (reset),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_beat  (s_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_beat  (m_beat)
    );

    // 4 ns clock
    always #2 aclk = ~aclk;

    // classic 32-bit lcg step
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in test %s, %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    // T lines open a test, B lines add a beat to the latest test
    task automatic read_vectors();
        int          fd;
        int          rc;
        string       line;
        string       kind;
        string       name;
        string       seq;
        int          mode;
        int          port;
        logic [31:0] data;
        logic [3:0]  keep;
        logic        user;
        logic        last;
        axis_beat_t  b;
        fd = $fopen("dv/axis_merge_vectors.txt", "r");
        if (fd == 0) begin
            $display("Error: the vector file dv/axis_merge_vectors.txt could not be opened");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            kind = "";
            rc = $fgets(line, fd);
            if (line.len() > 1)
                rc = $sscanf(line, "%s", kind);
            if (kind == "T") begin
                rc = $sscanf(line, "%s %s %d %s", kind, name, mode, seq);
                test_name.push_back(name);
                test_mode.push_back(mode);
                test_seq.push_back(seq);
            end else if (kind == "B") begin
                rc = $sscanf(line, "%s %d %h %h %h %h", kind, port, data, keep, user, last);
                if (port < 0 || port >= num_ports || test_name.size() == 0) begin
                    $display("Error: bad beat line in the vector file: %s", line);
                    errors++;
                end else begin
                    b.tdata = data;
                    b.tkeep = keep;
                    b.tuser = user;
                    b.tlast = last;
                    beat_test.push_back(test_name.size() - 1);
                    beat_port.push_back(port);
                    beat_val.push_back(b);
                end
            end
        end
        $fclose(fd);
        total_beats = beat_port.size();
    endtask

    // push one port's beats in order, hold each until s_ready takes it
    task automatic drive_port(int p);
        for (int i = 0; i < src_q[p].size(); i++) begin
            s_valid[p] <= 1'b1;
            s_beat[p]  <= src_q[p][i];
            @(posedge aclk);
            while (!s_ready[p])
                @(posedge aclk);
        end
        s_valid[p] <= 1'b0;
    endtask

    // mode 0 keeps m_ready high, mode 1 toggles it from the lcg
    task automatic gen_ready(int mode);
        logic [31:0] r;
        while (!test_done) begin
            if (mode == 1) begin
                r = lcg_next();
                m_ready <= r[16];
            end else begin
                m_ready <= 1'b1;
            end
            @(posedge aclk);
        end
        m_ready <= 1'b1;
    endtask

    // collect accepted output beats until the whole test has arrived
    task automatic monitor_beats(int n_beats, string seq);
        int           got;
        int           pkts;
        logic         open;
        logic [port_w-1:0] open_tid;
        merged_beat_t mb;
        axis_beat_t   eb;
        got  = 0;
        pkts = 0;
        open = 1'b0;
        open_tid = '0;
        while (got < n_beats) begin
            @(posedge aclk);
            if (m_valid && m_ready) begin
                mb = m_beat;
                got++;
                if (!open) begin
                    // packet start, tid order comes from the vector file
                    if (seq != "-" && pkts < seq.len())
                        check_value("packet tid", seq[pkts] - 8'h30, mb.tid);
                    pkts++;
                    open_tid = mb.tid;
                end else begin
                    // no other port may cut into an open packet
                    check_value("tid inside packet", open_tid, mb.tid);
                end
                open = !mb.beat.tlast;
                if (exp_q[mb.tid].size() == 0) begin
                    $display("Error: test %s got a beat from port %0d with none pending",
                             cur_test, mb.tid);
                    errors++;
                end else begin
                    eb = exp_q[mb.tid].pop_front();
                    check_value("tdata", eb.tdata, mb.beat.tdata);
                    check_value("tkeep", eb.tkeep, mb.beat.tkeep);
                    check_value("tuser", eb.tuser, mb.beat.tuser);
                    check_value("tlast", eb.tlast, mb.beat.tlast);
                end
            end
        end
        test_done = 1'b1;
        if (seq != "-")
            check_value("packet count", seq.len(), pkts);
    endtask

    task automatic run_test(int t);
        int   n;
        int   err0;
        int   a0;
        logic extra;
        cur_test = test_name[t];
        err0 = errors;
        a0 = dut_i.props_i.assert_errors;
        n = 0;
        for (int p = 0; p < num_ports; p++) begin
            src_q[p].delete();
            exp_q[p].delete();
        end
        foreach (beat_test[i]) begin
            if (beat_test[i] == t) begin
                src_q[beat_port[i]].push_back(beat_val[i]);
                exp_q[beat_port[i]].push_back(beat_val[i]);
                n++;
            end
        end
        // reset puts the round-robin pointer back on port 3
        reset     <= 1'b1;
        s_valid   <= '0;
        m_ready   <= 1'b0;
        test_done = 1'b0;
        repeat (4) @(posedge aclk);
        // all sources ready and no output beat straight after reset
        check_value("s_ready after reset", {num_ports{1'b1}}, s_ready);
        check_value("m_valid after reset", 0, m_valid);
        reset <= 1'b0;
        fork
            drive_port(0);
            drive_port(1);
            drive_port(2);
            drive_port(3);
            gen_ready(test_mode[t]);
            monitor_beats(n, test_seq[t]);
        join
        // watch for duplicated beats after the last expected one
        extra = 1'b0;
        repeat (8) begin
            @(posedge aclk);
            if (m_valid)
                extra = 1'b1;
        end
        if (extra) begin
            $display("Error: test %s sent more output beats than it received", cur_test);
            errors++;
        end
        for (int p = 0; p < num_ports; p++)
            check_value($sformatf("beats left on port %0d", p), 0, exp_q[p].size());
        if (dut_i.props_i.assert_errors != a0) begin
            $display("Error: test %s broke %0d concurrent assertions", cur_test,
                     dut_i.props_i.assert_errors - a0);
            errors++;
        end
        if (errors == err0)
            pass_count++;
        else
            fail_count++;
        $display("test %s: %s, %0d beats, %0d errors", cur_test,
                 (errors == err0) ? "ok" : "FAIL", n, errors - err0);
    endtask

    initial begin
        aclk        = 1'b0;
        reset       = 1'b1;
        s_valid     = '0;
        s_beat      = '0;
        m_ready     = 1'b0;
        errors      = 0;
        pass_count  = 0;
        fail_count  = 0;
        total_beats = 0;
        test_done   = 1'b0;
        lcg_state   = 32'h9a8f_a1ff;
        read_vectors();
        for (int t = 0; t < test_name.size(); t++)
            run_test(t);
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (errors == 0 && fail_count == 0 && pass_count > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // budget of 20 cycles per beat over the whole file
    initial begin
        int limit;
        wait (total_beats > 0);
        limit = total_beats * 20;
        repeat (limit) @(posedge aclk);
        $display("Error: timeout, the tests did not finish within %0d cycles", limit);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- dv/axis_merge_vectors.txt
# T <test name> <mode: 0 m_ready high, 1 random m_ready> <packet tid order, - for none>
# B <port> <tdata hex> <tkeep hex> <tuser> <tlast>, beats go to the latest T line

T single_port 0 2
B 2 a0000001 f 0 0
B 2 a0000002 3 1 0
B 2 a0000003 1 0 1

T packet_integrity 0 0123
B 0 b0000001 f 0 0
B 1 b1000001 f 1 0
B 2 b2000001 f 0 0
B 3 b3000001 7 1 1
B 0 b0000002 f 0 0
B 1 b1000002 3 0 1
B 2 b2000002 f 1 0
B 0 b0000003 1 1 1
B 2 b2000003 f 0 0
B 2 b2000004 f 0 1

T round_robin 0 01230123
B 0 c0000001 f 0 0
B 0 c0000002 f 0 1
B 0 c0000003 3 1 1
B 1 c1000001 f 0 1
B 1 c1000002 f 1 0
B 1 c1000003 7 0 1
B 2 c2000001 f 0 1
B 2 c2000002 1 0 1
B 3 c3000001 f 1 0
B 3 c3000002 f 0 1
B 3 c3000003 f 0 1

T random_backpressure 1 -
B 0 d0000001 f 0 0
B 1 d1000001 f 1 1
B 2 d2000001 f 0 0
B 3 d3000001 3 0 0
B 0 d0000002 f 1 0
B 1 d1000002 f 0 0
B 2 d2000002 1 1 1
B 3 d3000002 f 0 0
B 0 d0000003 7 0 1
B 1 d1000003 f 0 1
B 3 d3000003 f 1 1

T sparse_ports 0 1313
B 1 e1000001 f 0 0
B 1 e1000002 f 0 1
B 3 e3000001 3 1 1
B 1 e1000003 f 1 1
B 3 e3000002 f 0 0
B 3 e3000003 1 0 1

//--- build.f
logic/axis_merge_pkg.sv
logic/axis_skid_buffer.sv
logic/packet_arbiter.sv
logic/merge_output_stage.sv
logic/axis_merge_top.sv
dv/axis_merge_props.sv
dv/axis_merge_tb.sv
